//--- build.f
+incdir+design
design/rp_pkg.sv
design/rp_dec.sv
design/rp_gpr.sv
design/rp_br.sv
design/rp_alu.sv
design/rp_lsu.sv
design/rp32_core.sv
tb/tb_mem.sv
tb/tb_rp32_core.sv

//--- design/rp32_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module rp32_core import rp_pkg::*; (
  input  logic                        clk,
  input  logic                        rst,
  // program bus
  output logic                        bup_req,
  output logic [`RP_PAW-1:0]          bup_adr,
  input  logic [`RP_XW/8-1:0][8-1:0]  bup_rdt,
  input  logic                        bup_ack,
  // data bus
  output logic                        bud_req,
  output logic                        bud_wen,
  output logic [`RP_XW/8-1:0]         bud_sel,
  output logic [`RP_DAW-1:0]          bud_adr,
  output logic [`RP_XW/8-1:0][8-1:0]  bud_wdt,
  input  logic [`RP_XW/8-1:0][8-1:0]  bud_rdt,
  input  logic                        bud_ack
);

  // register address width, 16 registers for rv32e
  localparam int unsigned AW = (`RP_ISA_E != 0) ? 4 : 5;

  logic [31:0]         ins;
  ctl_t                ctl;
  logic                tkn;
  logic                stall;
  logic [`RP_PAW-1:0]  pc;
  logic [`RP_PAW-1:0]  pc4;
  logic [`RP_PAW-1:0]  pcn;
  logic [`RP_XW-1:0]   gpr_rs1;
  logic [`RP_XW-1:0]   gpr_rs2;
  logic [`RP_XW-1:0]   gpr_rd;
  logic [`RP_XW-1:0]   alu_rs1;
  logic [`RP_XW-1:0]   alu_rs2;
  logic [`RP_XW-1:0]   alu_rd;
  logic [`RP_XW-1:0]   alu_sum;
  logic [`RP_XW-1:0]   ldt;

  ////////////////////////////////////////////////////////////
  // fetch
  ////////////////////////////////////////////////////////////

  // request rises at the first clock after reset and stays
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bup_req <= 1'b0;
    end else begin
      bup_req <= 1'b1;
    end
  end

  // retire needs the fetch ack, plus the data ack for loads and stores
  assign stall = ~(bup_ack && ((ctl.ls == LS_NONE) || bud_ack));

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc <= `RP_PC0;
    end else if (~stall) begin
      pc <= pcn;
    end
  end

  assign bup_adr = pc;
  assign pc4     = pc + 'd4;

  // taken branch, jal and jalr all use the adder
  always_comb begin
    if (tkn) begin
      pcn = ctl.jalr ? {alu_sum[`RP_PAW-1:1], 1'b0} : alu_sum[`RP_PAW-1:0];
    end else begin
      pcn = pc4;
    end
  end

  ////////////////////////////////////////////////////////////
  // decode and registers
  ////////////////////////////////////////////////////////////

  assign ins = bup_rdt;

  rp_dec dec (
    .ins (ins),
    .ctl (ctl)
  );

  // write lands only on the retire edge
  rp_gpr #(
    .AW (AW)
  ) gpr (
    .clk   (clk),
    .rst   (rst),
    .e_rd  (~stall && (ctl.wb != WB_NONE)),
    .a_rs1 (ins[15 +: AW]),
    .a_rs2 (ins[20 +: AW]),
    .a_rd  (ins[7 +: AW]),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2),
    .d_rd  (gpr_rd)
  );

  ////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////

  rp_br br (
    .ctl (ctl.br),
    .rs1 (gpr_rs1),
    .rs2 (gpr_rs2),
    .tkn (tkn)
  );

  // operand muxes
  always_comb begin
    case (ctl.a1)
      A1_PC:   alu_rs1 = pc;
      A1_ZERO: alu_rs1 = '0;
      default: alu_rs1 = gpr_rs1;
    endcase
    alu_rs2 = (ctl.a2 == A2_IMM) ? ctl.imm : gpr_rs2;
  end

  rp_alu alu (
    .ctl (ctl.ao),
    .rs1 (alu_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  ////////////////////////////////////////////////////////////
  // load/store and write-back
  ////////////////////////////////////////////////////////////

  // request held by the fetch ack until the data ack
  rp_lsu lsu (
    .req     (bup_ack),
    .ls      (ctl.ls),
    .f3      (ctl.f3),
    .adr     (alu_sum),
    .wdt     (gpr_rs2),
    .bud_req (bud_req),
    .bud_wen (bud_wen),
    .bud_sel (bud_sel),
    .bud_adr (bud_adr),
    .bud_wdt (bud_wdt),
    .bud_rdt (bud_rdt),
    .ldt     (ldt)
  );

  always_comb begin
    case (ctl.wb)
      WB_MEM:  gpr_rd = ldt;
      WB_PC4:  gpr_rd = pc4;
      default: gpr_rd = alu_rd;
    endcase
  end

endmodule: rp32_core

`default_nettype wire

//--- design/rp_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module rp_alu import rp_pkg::*; (
  input  ao_t               ctl,
  input  logic [`RP_XW-1:0] rs1,
  input  logic [`RP_XW-1:0] rs2,
  output logic [`RP_XW-1:0] rd,
  output logic [`RP_XW-1:0] sum
);

  logic [4:0] sh;

  // shift amount from the low five bits
  assign sh = rs2[4:0];

  // jump target and memory address
  assign sum = rs1 + rs2;

  always_comb begin
    case (ctl)
      AO_ADD:  rd = sum;
      AO_SUB:  rd = rs1 - rs2;
      AO_SLL:  rd = rs1 << sh;
      AO_SLT:  rd = {{(`RP_XW-1){1'b0}}, $signed(rs1) < $signed(rs2)};
      AO_SLTU: rd = {{(`RP_XW-1){1'b0}}, rs1 < rs2};
      AO_XOR:  rd = rs1 ^ rs2;
      AO_SRL:  rd = rs1 >> sh;
      // arithmetic shift keeps the sign
      AO_SRA:  rd = $signed(rs1) >>> sh;
      AO_OR:   rd = rs1 | rs2;
      AO_AND:  rd = rs1 & rs2;
      default: rd = sum;
    endcase
  end

endmodule: rp_alu

`default_nettype wire

//--- design/rp_br.sv
`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module rp_br import rp_pkg::*; (
  input  br_t               ctl,
  input  logic [`RP_XW-1:0] rs1,
  input  logic [`RP_XW-1:0] rs2,
  output logic              tkn
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (rs1 == rs2);
  assign lt  = ($signed(rs1) < $signed(rs2));
  assign ltu = (rs1 < rs2);

  always_comb begin
    case (ctl)
      BR_EQ:   tkn = eq;
      BR_NE:   tkn = ~eq;
      BR_LT:   tkn = lt;
      BR_GE:   tkn = ~lt;
      BR_LTU:  tkn = ltu;
      BR_GEU:  tkn = ~ltu;
      // jal and jalr
      BR_JMP:  tkn = 1'b1;
      default: tkn = 1'b0;
    endcase
  end

endmodule: rp_br

`default_nettype wire

//--- design/rp_cfg.svh
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// program bus address width
`define RP_PAW 32
// data bus address width
`define RP_DAW 32
// integer register width, also data bus width
`define RP_XW 32

// fetch address out of reset
`define RP_PC0 32'h0000_0000

// 1 for RV32E (16 registers), 0 for RV32I
`define RP_ISA_E 0

`endif

//--- design/rp_dec.sv
`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module rp_dec import rp_pkg::*; (
  input  logic [31:0] ins,
  output ctl_t        ctl
);

  opc_t              opc;
  logic [2:0]        f3;
  logic [`RP_XW-1:0] imm_i;
  logic [`RP_XW-1:0] imm_s;
  logic [`RP_XW-1:0] imm_b;
  logic [`RP_XW-1:0] imm_u;
  logic [`RP_XW-1:0] imm_j;

  assign opc = opc_t'(ins[6:0]);
  assign f3  = ins[14:12];

  //////////////////////////////////////////////////////////
  // immediates, all sign extended from bit 31
  //////////////////////////////////////////////////////////

  assign imm_i = {{20{ins[31]}}, ins[31:20]};
  assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  assign imm_u = {ins[31:12], 12'b0};
  assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

  //////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////

  always_comb begin
    // no-op unless the opcode says otherwise
    ctl      = '0;
    ctl.ao   = AO_ADD;
    ctl.br   = BR_NONE;
    ctl.a1   = A1_RS1;
    ctl.a2   = A2_IMM;
    ctl.wb   = WB_NONE;
    ctl.ls   = LS_NONE;
    ctl.f3   = f3;
    ctl.jalr = 1'b0;
    ctl.imm  = imm_i;
    case (opc)
      OPC_LUI: begin
        ctl.a1  = A1_ZERO;
        ctl.imm = imm_u;
        ctl.wb  = WB_ALU;
      end
      OPC_AUIPC: begin
        ctl.a1  = A1_PC;
        ctl.imm = imm_u;
        ctl.wb  = WB_ALU;
      end
      OPC_JAL: begin
        // target from pc + imm on the adder
        ctl.a1  = A1_PC;
        ctl.imm = imm_j;
        ctl.br  = BR_JMP;
        ctl.wb  = WB_PC4;
      end
      OPC_JALR: begin
        ctl.br   = BR_JMP;
        ctl.jalr = 1'b1;
        ctl.wb   = WB_PC4;
      end
      OPC_BRANCH: begin
        ctl.a1  = A1_PC;
        ctl.imm = imm_b;
        case (f3)
          3'b000:  ctl.br = BR_EQ;
          3'b001:  ctl.br = BR_NE;
          3'b100:  ctl.br = BR_LT;
          3'b101:  ctl.br = BR_GE;
          3'b110:  ctl.br = BR_LTU;
          3'b111:  ctl.br = BR_GEU;
          default: ctl.br = BR_NONE;
        endcase
      end
      OPC_LOAD: begin
        ctl.ls = LS_LOAD;
        ctl.wb = WB_MEM;
      end
      OPC_STORE: begin
        ctl.ls  = LS_STORE;
        ctl.imm = imm_s;
      end
      OPC_OP_IMM, OPC_OP: begin
        ctl.wb = WB_ALU;
        if (opc == OPC_OP) begin
          ctl.a2 = A2_RS2;
        end
        case (f3)
          // sub only exists in the register form
          3'b000:  ctl.ao = (opc == OPC_OP && ins[30]) ? AO_SUB : AO_ADD;
          3'b001:  ctl.ao = AO_SLL;
          3'b010:  ctl.ao = AO_SLT;
          3'b011:  ctl.ao = AO_SLTU;
          3'b100:  ctl.ao = AO_XOR;
          3'b101:  ctl.ao = ins[30] ? AO_SRA : AO_SRL;
          3'b110:  ctl.ao = AO_OR;
          default: ctl.ao = AO_AND;
        endcase
      end
      default: begin
        ctl.wb = WB_NONE;
        ctl.ls = LS_NONE;
      end
    endcase
  end

endmodule: rp_dec

`default_nettype wire

//--- design/rp_gpr.sv
`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module rp_gpr #(
  int unsigned AW = 5
)(
  input  logic              clk,
  input  logic              rst,
  input  logic              e_rd,
  input  logic [AW-1:0]     a_rs1,
  input  logic [AW-1:0]     a_rs2,
  input  logic [AW-1:0]     a_rd,
  output logic [`RP_XW-1:0] d_rs1,
  output logic [`RP_XW-1:0] d_rs2,
  input  logic [`RP_XW-1:0] d_rd
);

  logic [`RP_XW-1:0] gpr [0:2**AW-1];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 2**AW; i++) begin
        gpr[i] <= '0;
      end
    end else if (e_rd && (a_rd != '0)) begin
      gpr[a_rd] <= d_rd;
    end
  end

  // asynchronous reads
  assign d_rs1 = gpr[a_rs1];
  assign d_rs2 = gpr[a_rs2];

endmodule: rp_gpr

`default_nettype wire

//--- design/rp_lsu.sv
`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module rp_lsu import rp_pkg::*; (
  input  logic                 req,
  input  ls_t                  ls,
  input  logic [2:0]           f3,
  input  logic [31:0]          adr,
  input  logic [31:0]          wdt,
  output logic                 bud_req,
  output logic                 bud_wen,
  output logic [`RP_XW/8-1:0]  bud_sel,
  output logic [`RP_DAW-1:0]   bud_adr,
  output logic [`RP_XW-1:0]    bud_wdt,
  input  logic [`RP_XW-1:0]    bud_rdt,
  output logic [31:0]          ldt
);

  logic [7:0]  ld_b;
  logic [15:0] ld_h;

  assign bud_req = req && (ls != LS_NONE);
  assign bud_wen = (ls == LS_STORE);
  // word aligned, low bits go to the byte select
  assign bud_adr = {adr[`RP_DAW-1:2], 2'b00};

  //////////////////////////////////////////////////////////
  // store lanes
  //////////////////////////////////////////////////////////

  always_comb begin
    case (f3[1:0])
      2'b00: begin
        bud_sel = 4'b0001 << adr[1:0];
        bud_wdt = {4{wdt[7:0]}};
      end
      2'b01: begin
        bud_sel = adr[1] ? 4'b1100 : 4'b0011;
        bud_wdt = {2{wdt[15:0]}};
      end
      default: begin
        bud_sel = 4'b1111;
        bud_wdt = wdt;
      end
    endcase
  end

  //////////////////////////////////////////////////////////
  // load extraction
  //////////////////////////////////////////////////////////

  assign ld_b = bud_rdt[8*adr[1:0] +: 8];
  assign ld_h = adr[1] ? bud_rdt[31:16] : bud_rdt[15:0];

  // f3[2] set means zero extension
  always_comb begin
    case (f3[1:0])
      2'b00:   ldt = {{24{~f3[2] & ld_b[7]}}, ld_b};
      2'b01:   ldt = {{16{~f3[2] & ld_h[15]}}, ld_h};
      default: ldt = bud_rdt;
    endcase
  end

endmodule: rp_lsu

`default_nettype wire

//--- design/rp_pkg.sv
`default_nettype none

`include "rp_cfg.svh"

package rp_pkg;

  // major opcodes in instr[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opc_t;

  // alu operation
  typedef enum logic [3:0] {
    AO_ADD, AO_SUB, AO_SLL, AO_SLT, AO_SLTU,
    AO_XOR, AO_SRL, AO_SRA, AO_OR, AO_AND
  } ao_t;

  // branch condition, jmp is unconditional
  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JMP
  } br_t;

  // operand sources
  typedef enum logic [1:0] {A1_RS1, A1_PC, A1_ZERO} a1_t;
  typedef enum logic {A2_RS2, A2_IMM} a2_t;

  // write-back source
  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC4} wb_t;

  // data bus access
  typedef enum logic [1:0] {LS_NONE, LS_LOAD, LS_STORE} ls_t;

  // decoded control, 50 bits
  typedef struct packed {
    ao_t              ao;
    br_t              br;
    a1_t              a1;
    a2_t              a2;
    wb_t              wb;
    ls_t              ls;
    // size in [1:0], unsigned load in [2]
    logic [2:0]       f3;
    logic             jalr;
    logic [`RP_XW-1:0] imm;
  } ctl_t;

endpackage: rp_pkg

`default_nettype wire

//--- tb/tb_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem (
  input  logic        clk,
  input  logic        rst,
  // program bus
  input  logic        bup_req,
  input  logic [31:0] bup_adr,
  output logic [31:0] bup_rdt,
  output logic        bup_ack,
  // data bus
  input  logic        bud_req,
  input  logic        bud_wen,
  input  logic [3:0]  bud_sel,
  input  logic [31:0] bud_adr,
  input  logic [31:0] bud_wdt,
  output logic [31:0] bud_rdt,
  output logic        bud_ack
);

  // shared program and data words, 1 KiB
  logic [31:0] mem [0:255];
  logic        retired;
  int unsigned p_cnt;
  int unsigned d_cnt;

  assign bup_rdt = mem[bup_adr[9:2]];
  assign bud_rdt = mem[bud_adr[9:2]];

  // retire seen by the core at this edge, store lanes land here too
  always @(posedge clk) begin
    retired <= !rst && bup_ack && (!bud_req || bud_ack);
    if (!rst && bud_req && bud_wen && bud_ack) begin
      for (int b = 0; b < 4; b++) begin
        if (bud_sel[b]) begin
          mem[bud_adr[9:2]][8*b +: 8] <= bud_wdt[8*b +: 8];
        end
      end
    end
  end

  // acks move on the falling edge, 0 to 3 wait cycles each
  always @(negedge clk) begin
    if (rst) begin
      bup_ack <= 1'b0;
      bud_ack <= 1'b0;
      p_cnt   <= 0;
      d_cnt   <= 0;
    end else if (retired) begin
      bup_ack <= 1'b0;
      bud_ack <= 1'b0;
      p_cnt   <= $urandom % 4;
      d_cnt   <= $urandom % 4;
    end else begin
      if (bup_req && !bup_ack) begin
        if (p_cnt == 0) bup_ack <= 1'b1;
        else p_cnt <= p_cnt - 1;
      end
      if (bud_req && !bud_ack) begin
        if (d_cnt == 0) bud_ack <= 1'b1;
        else d_cnt <= d_cnt - 1;
      end
    end
  end

endmodule: tb_mem

`default_nettype wire

//--- tb/tb_rp32_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rp32_core;

  localparam logic [31:0] seed = 32'h12df_93b6;
  // 200 instructions at about 5 cycles each
  localparam int max_insns    = 200;
  localparam int cyc_per_insn = 5;
  localparam int timeout      = max_insns * cyc_per_insn;

  // major opcodes
  localparam logic [6:0] op_lui   = 7'h37;
  localparam logic [6:0] op_auipc = 7'h17;
  localparam logic [6:0] op_jal   = 7'h6f;
  localparam logic [6:0] op_jalr  = 7'h67;
  localparam logic [6:0] op_br    = 7'h63;
  localparam logic [6:0] op_load  = 7'h03;
  localparam logic [6:0] op_store = 7'h23;
  localparam logic [6:0] op_imm   = 7'h13;
  localparam logic [6:0] op_reg   = 7'h33;

  logic        clk;
  logic        rst;
  logic        bup_req;
  logic [31:0] bup_adr;
  logic [31:0] bup_rdt;
  logic        bup_ack;
  logic        bud_req;
  logic        bud_wen;
  logic [3:0]  bud_sel;
  logic [31:0] bud_adr;
  logic [31:0] bud_wdt;
  logic [31:0] bud_rdt;
  logic        bud_ack;

  // expected stores and retire path
  logic [31:0] exp_adr [$];
  logic [3:0]  exp_sel [$];
  logic [31:0] exp_dat [$];
  int          exp_tst [$];
  logic [31:0] exp_path [$];
  string       tname [5] = '{"imm_arith", "reg_reg", "control", "partial_st", "load_ext"};
  int          remaining [5];
  int          seen [5];
  int          terrs [5];
  int          errors;
  int          checked;
  int          cycles;
  bit          done;
  int unsigned pc_asm;
  int unsigned doff;

  // previous cycle, for the hold checks
  logic        wait_d;
  logic        wait_p;
  logic [31:0] prev_dadr;
  logic [31:0] prev_wdt;
  logic [3:0]  prev_sel;
  logic        prev_wen;
  logic [31:0] prev_padr;

  rp32_core u_dut (
    .clk     (clk),
    .rst     (rst),
    .bup_req (bup_req),
    .bup_adr (bup_adr),
    .bup_rdt (bup_rdt),
    .bup_ack (bup_ack),
    .bud_req (bud_req),
    .bud_wen (bud_wen),
    .bud_sel (bud_sel),
    .bud_adr (bud_adr),
    .bud_wdt (bud_wdt),
    .bud_rdt (bud_rdt),
    .bud_ack (bud_ack)
  );

  tb_mem u_mem (
    .clk     (clk),
    .rst     (rst),
    .bup_req (bup_req),
    .bup_adr (bup_adr),
    .bup_rdt (bup_rdt),
    .bup_ack (bup_ack),
    .bud_req (bud_req),
    .bud_wen (bud_wen),
    .bud_sel (bud_sel),
    .bud_adr (bud_adr),
    .bud_wdt (bud_wdt),
    .bud_rdt (bud_rdt),
    .bud_ack (bud_ack)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  ////////////////////////////////////////////////////////////
  // program builder
  ////////////////////////////////////////////////////////////

  // on_path clear for words that must never retire
  task automatic emit(input logic [31:0] w, input bit on_path);
    u_mem.mem[pc_asm[9:2]] = w;
    if (on_path) exp_path.push_back(pc_asm);
    pc_asm += 4;
  endtask

  task automatic expect_store(input int t, input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
    exp_tst.push_back(t);
    exp_adr.push_back(adr);
    exp_sel.push_back(sel);
    exp_dat.push_back(dat);
    remaining[t]++;
  endtask

  // sw rs into the next result word above x10
  task automatic store_word(input int t, input logic [4:0] rs, input logic [31:0] val);
    emit(enc_s(doff, rs, 5'd10, 3'b010), 1);
    expect_store(t, 32'h200 + doff, 4'b1111, val);
    doff += 4;
  endtask

  // store the marker 0xBA from x21, only reached by a wrong jump
  task automatic skipped_store();
    emit(enc_s(32'h1F0, 5'd21, 5'd10, 3'b010), 0);
  endtask

  task automatic build_program();
    int unsigned pa;
    pc_asm = 0;
    doff   = 0;
    emit(enc_i(512, 5'd0, 3'b000, 5'd10, op_imm), 1);
    // immediate arithmetic
    emit(enc_i(-5, 5'd0, 3'b000, 5'd1, op_imm), 1);
    store_word(0, 5'd1, 32'hFFFF_FFFB);
    emit(enc_i(32'h0F0, 5'd1, 3'b100, 5'd2, op_imm), 1);
    store_word(0, 5'd2, 32'hFFFF_FF0B);
    emit(enc_i(-4, 5'd1, 3'b010, 5'd3, op_imm), 1);
    store_word(0, 5'd3, 32'h1);
    emit(enc_i(4, 5'd1, 3'b001, 5'd4, op_imm), 1);
    store_word(0, 5'd4, 32'hFFFF_FFB0);
    emit(enc_i(32'h401, 5'd1, 3'b101, 5'd5, op_imm), 1);
    store_word(0, 5'd5, 32'hFFFF_FFFD);
    emit(enc_u(20'h12345, 5'd6, op_lui), 1);
    store_word(0, 5'd6, 32'h1234_5000);
    pa = pc_asm;
    emit(enc_u(20'h00001, 5'd7, op_auipc), 1);
    store_word(0, 5'd7, pa + 32'h1000);
    emit(enc_i(123, 5'd0, 3'b000, 5'd0, op_imm), 1);
    store_word(0, 5'd0, 32'h0);
    // register-register on edge values
    emit(enc_u(20'h80000, 5'd11, op_lui), 1);
    emit(enc_i(-1, 5'd0, 3'b000, 5'd12, op_imm), 1);
    emit(enc_i(1, 5'd0, 3'b000, 5'd13, op_imm), 1);
    emit(enc_r(7'h00, 5'd12, 5'd11, 3'b000, 5'd14), 1);
    store_word(1, 5'd14, 32'h7FFF_FFFF);
    emit(enc_r(7'h20, 5'd11, 5'd13, 3'b000, 5'd15), 1);
    store_word(1, 5'd15, 32'h8000_0001);
    emit(enc_r(7'h00, 5'd13, 5'd11, 3'b010, 5'd16), 1);
    store_word(1, 5'd16, 32'h1);
    emit(enc_r(7'h00, 5'd13, 5'd11, 3'b011, 5'd17), 1);
    store_word(1, 5'd17, 32'h0);
    emit(enc_r(7'h00, 5'd13, 5'd11, 3'b101, 5'd18), 1);
    store_word(1, 5'd18, 32'h4000_0000);
    emit(enc_r(7'h00, 5'd12, 5'd11, 3'b111, 5'd19), 1);
    store_word(1, 5'd19, 32'h8000_0000);
    emit(enc_r(7'h00, 5'd13, 5'd11, 3'b110, 5'd20), 1);
    store_word(1, 5'd20, 32'h8000_0001);
    // branches, taken ones jump over a marker store
    emit(enc_i(32'h0BA, 5'd0, 3'b000, 5'd21, op_imm), 1);
    emit(enc_b(8, 5'd13, 5'd13, 3'b000), 1);
    skipped_store();
    emit(enc_b(8, 5'd13, 5'd13, 3'b001), 1);
    store_word(2, 5'd13, 32'h1);
    emit(enc_b(8, 5'd13, 5'd11, 3'b100), 1);
    skipped_store();
    emit(enc_b(8, 5'd11, 5'd13, 3'b111), 1);
    store_word(2, 5'd12, 32'hFFFF_FFFF);
    // jal over one word, link is pc + 4
    pa = pc_asm;
    emit(enc_j(8, 5'd22), 1);
    skipped_store();
    store_word(2, 5'd22, pa + 4);
    // jalr with an odd offset, bit 0 dropped
    pa = pc_asm;
    emit(enc_u(20'h0, 5'd23, op_auipc), 1);
    emit(enc_i(17, 5'd23, 3'b000, 5'd24, op_jalr), 1);
    skipped_store();
    skipped_store();
    store_word(2, 5'd24, pa + 8);
    // byte and half stores of 0x11223344 into two words
    emit(enc_u(20'h11223, 5'd25, op_lui), 1);
    emit(enc_i(32'h344, 5'd25, 3'b000, 5'd25, op_imm), 1);
    for (int k = 0; k < 4; k++) begin
      emit(enc_s(doff + k, 5'd25, 5'd10, 3'b000), 1);
      expect_store(3, 32'h200 + doff, 4'b0001 << k, 32'h44 << (8 * k));
    end
    emit(enc_s(doff + 4, 5'd25, 5'd10, 3'b001), 1);
    expect_store(3, 32'h204 + doff, 4'b0011, 32'h0000_3344);
    emit(enc_s(doff + 6, 5'd25, 5'd10, 3'b001), 1);
    expect_store(3, 32'h204 + doff, 4'b1100, 32'h3344_0000);
    doff += 8;
    // loads from 0x300, which holds 0x8001_0080
    emit(enc_i(32'h100, 5'd10, 3'b000, 5'd26, op_load), 1);
    store_word(4, 5'd26, 32'hFFFF_FF80);
    emit(enc_i(32'h100, 5'd10, 3'b100, 5'd27, op_load), 1);
    store_word(4, 5'd27, 32'h0000_0080);
    emit(enc_i(32'h102, 5'd10, 3'b001, 5'd28, op_load), 1);
    store_word(4, 5'd28, 32'hFFFF_8001);
    emit(enc_i(32'h102, 5'd10, 3'b101, 5'd29, op_load), 1);
    store_word(4, 5'd29, 32'h0000_8001);
    // end marker, then spin
    emit(enc_i(32'h5A5, 5'd0, 3'b000, 5'd5, op_imm), 1);
    emit(enc_s(32'h3FC, 5'd5, 5'd0, 3'b010), 1);
    emit(enc_j(0, 5'd0), 0);
  endtask

  ////////////////////////////////////////////////////////////
  // monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] mask;
    logic [31:0] pexp;
    int          t;
    if (!rst) begin
      cycles <= cycles + 1;
      // fetch request comes up one clock after reset and stays up
      assert (bup_req == (cycles != 0))
      else begin
        $display("fetch request is %b at cycle %0d after reset", bup_req, cycles);
        errors++;
      end
      // data request only while a fetched load or store is acknowledged
      assert (bud_req == (bup_ack
                          && (bup_rdt[6:0] == op_load || bup_rdt[6:0] == op_store)))
      else begin
        $display("data request is %b for fetched word %h at %0t", bud_req, bup_rdt, $time);
        errors++;
      end
      // ack delays must not move any request field
      if (wait_d) begin
        assert (bud_adr == prev_dadr && bud_sel == prev_sel && bud_wen == prev_wen
                && bud_wdt == prev_wdt)
        else begin
          $display("data bus request changed while waiting for ack at %0t", $time);
          errors++;
        end
      end
      if (wait_p) begin
        assert (bup_adr == prev_padr)
        else begin
          $display("fetch address changed while waiting for ack at %0t", $time);
          errors++;
        end
      end
      // retire path
      if (bup_ack && (!bud_req || bud_ack) && !done && exp_path.size() > 0) begin
        pexp = exp_path.pop_front();
        assert (bup_adr == pexp)
        else begin
          $display("CHECK FAILED control_path: expected %h actual %h", pexp, bup_adr);
          errors++;
        end
      end
      if (bud_req && bud_wen && bud_ack && !done) begin
        mask = {{8{bud_sel[3]}}, {8{bud_sel[2]}}, {8{bud_sel[1]}}, {8{bud_sel[0]}}};
        if (bud_adr == 32'h3FC) begin
          assert (bud_wdt == 32'h5A5)
          else begin
            $display("CHECK FAILED end_marker: expected %h actual %h", 32'h5A5, bud_wdt);
            errors++;
          end
          done = 1'b1;
        end else if (exp_adr.size() == 0) begin
          $display("unexpected store to %h with data %h", bud_adr, bud_wdt);
          errors++;
        end else begin
          t = exp_tst.pop_front();
          assert (bud_adr == exp_adr[0] && bud_sel == exp_sel[0]
                  && (bud_wdt & mask) == exp_dat[0])
          else begin
            $display("CHECK FAILED %s: adr/sel/data expected %h %b %h actual %h %b %h",
                     tname[t], exp_adr[0], exp_sel[0], exp_dat[0],
                     bud_adr, bud_sel, bud_wdt & mask);
            errors++;
            terrs[t]++;
          end
          void'(exp_adr.pop_front());
          void'(exp_sel.pop_front());
          void'(exp_dat.pop_front());
          checked++;
          seen[t]++;
          remaining[t]--;
          if (remaining[t] == 0) begin
            $display("test %s: %0d stores, %0d errors", tname[t], seen[t], terrs[t]);
          end
        end
      end
    end
    wait_d    <= !rst && bud_req && !bud_ack;
    wait_p    <= !rst && bup_req && !bup_ack;
    prev_dadr <= bud_adr;
    prev_sel  <= bud_sel;
    prev_wen  <= bud_wen;
    prev_wdt  <= bud_wdt;
    prev_padr <= bup_adr;
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(seed));
    clk     = 1'b0;
    rst     = 1'b1;
    errors  = 0;
    checked = 0;
    cycles  = 0;
    done    = 1'b0;
    for (int i = 0; i < 5; i++) begin
      remaining[i] = 0;
      seen[i]      = 0;
      terrs[i]     = 0;
    end
    // fill with address tagged words, opcode field stays unknown
    for (int i = 0; i < 256; i++) begin
      u_mem.mem[i] = 32'hDEAD_0000 | (i << 8);
    end
    build_program();
    u_mem.mem[32'h300 >> 2] = 32'h8001_0080;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    while (!done && cycles < timeout) @(negedge clk);
    if (!done) begin
      $display("timeout after %0d cycles without the end marker store", cycles);
      errors++;
    end
    if (exp_adr.size() != 0) begin
      $display("%0d expected stores were never seen", exp_adr.size());
      errors++;
    end
    if (exp_path.size() != 0) begin
      $display("%0d expected fetch addresses never retired", exp_path.size());
      errors++;
    end
    $display("tests 5, stores checked %0d, cycles %0d, errors %0d", checked, cycles, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule: tb_rp32_core

`default_nettype wire
